/* sources.f */
logic/pio_pkg.sv
logic/pio_loader.sv
logic/pio_decode.sv
logic/pio_execute.sv
logic/pio_result.sv
logic/pio.sv
logic/pio_board_top.sv
test/pio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the PIO testbench with Verilator
# Exit status is nonzero when the testbench stops on a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module pio_tb \
  -f sources.f \
  -o pio_tb_sim

./obj_dir/pio_tb_sim

/* test/pio_tb.sv */
`timescale 1ns/1ps
module pio_tb;

  localparam int tick_clocks = 2;                // Divider set by the loader
  localparam int bit_clocks  = 8 * tick_clocks;  // 8 ticks per UART bit
  localparam int high_ticks  = 2;                // set pins 1 [1]
  localparam int low_ticks   = 2;                // set pins 0, then jmp 1
  localparam int square_runs = 10;
  localparam int lcg_frames  = 6;
  // Up to 16 frames of ~170 clocks, 4 loads of ~50, 2 square runs, doubled
  localparam int max_cycles  = 6000;

  logic        clk_25mhz;
  logic [6:0]  btn;           // btn[0] low is reset
  logic [7:0]  led;
  logic [27:0] gn;
  int          cycles;
  int          reset_clocks;  // Clocks seen with reset held
  logic [31:0] lcg_state;

  pio_board_top u_pio_board_top (
    .clk_25mhz(clk_25mhz), .btn(btn), .led(led), .gn(gn)
  );

  initial clk_25mhz = 1'b0;
  always #20 clk_25mhz = ~clk_25mhz; // 25 MHz

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // Expected line levels, start bit first
  function automatic logic [9:0] uart_frame(input logic [7:0] data);
    logic [9:0] f;
    f[0] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      f[i+1] = data[i]; // LSB first
    end
    f[9] = 1'b1;
    return f;
  endfunction

  // Clocks that gn[0] stays at one level
  function automatic int square_run(input logic level);
    return (level ? high_ticks : low_ticks) * tick_clocks;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reset values and unused pins, sampled mid-cycle
  always @(negedge clk_25mhz) begin
    compare_values("gn[27:16]", {20'b0, gn[27:16]}, 32'd0);
    compare_values("led[6:2]", {27'b0, led[6:2]}, 32'd0); // Spare LEDs stay dark
    if (!btn[0]) begin
      if (reset_clocks > 0) begin // Regs cleared after the first edge
        compare_values("gn in reset", {4'b0, gn}, 32'd0);
        compare_values("led[0] in reset", {31'b0, led[0]}, 32'd0);
        compare_values("led[7] in reset", {31'b0, led[7]}, 32'd1);
      end
      reset_clocks = reset_clocks + 1;
    end else begin
      compare_values("led[7] out of reset", {31'b0, led[7]}, 32'd0);
      reset_clocks = 0;
    end
  end

  always @(posedge clk_25mhz) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic apply_reset(input logic uart, input logic [4:0] data);
    @(posedge clk_25mhz);
    #1;
    btn = {data, uart, 1'b0}; // Mode is captured during reset
    repeat (8) @(posedge clk_25mhz);
    #1;
    btn[0] = 1'b1;
  endtask

  task automatic set_data(input logic [4:0] data);
    @(posedge clk_25mhz);
    #1;
    btn[6:2] = data;
  endtask

  // Returns at the first low sample after a high one
  task automatic wait_start_edge();
    logic prev;
    @(negedge clk_25mhz);
    prev = gn[0];
    @(negedge clk_25mhz);
    while (!(prev && !gn[0])) begin
      prev = gn[0];
      @(negedge clk_25mhz);
    end
  endtask

  task automatic receive_frame(output logic [9:0] bits);
    wait_start_edge();
    repeat (bit_clocks / 2) @(negedge clk_25mhz); // Bit center
    for (int i = 0; i < 10; i++) begin
      bits[i] = gn[0];
      if (i < 9) repeat (bit_clocks) @(negedge clk_25mhz);
    end
  endtask

  task automatic check_frame(input logic [4:0] data);
    logic [9:0] bits;
    receive_frame(bits);
    compare_values("uart frame", {22'b0, bits}, {22'b0, uart_frame({3'b0, data})});
  endtask

  task automatic run_square();
    logic prev;
    logic level;
    int   run;
    @(negedge clk_25mhz);
    prev = gn[0];
    @(negedge clk_25mhz);
    while (!(!prev && gn[0])) begin // First rising edge
      prev = gn[0];
      @(negedge clk_25mhz);
    end
    compare_values("led[1]", {31'b0, led[1]}, 32'd1);
    compare_values("gn[8]", {31'b0, gn[8]}, 32'd1);
    for (int e = 0; e < square_runs; e++) begin
      level = gn[0];
      run = 0;
      while (gn[0] == level) begin
        run = run + 1;
        @(negedge clk_25mhz);
      end
      if (level) compare_values("gn[0] high clocks", run, square_run(1'b1));
      else       compare_values("gn[0] low clocks", run, square_run(1'b0));
    end
  endtask

  initial begin
    logic [4:0] data;
    logic [4:0] old_data;
    logic [9:0] bits;
    cycles       = 0;
    reset_clocks = 0;
    lcg_state    = 32'h1f1a;
    btn          = 7'b0000000; // Reset held, square mode
    repeat (8) @(posedge clk_25mhz);
    #1;
    btn[0] = 1'b1;

    run_square();

    // UART mode, first byte straight from reset
    lcg_state = lcg_next(lcg_state);
    data = lcg_state[20:16];
    apply_reset(1'b1, data);
    check_frame(data);
    compare_values("led[1]", {31'b0, led[1]}, 32'd1);
    compare_values("gn[8]", {31'b0, gn[8]}, 32'd1);

    // New byte between frames, one old frame may still be queued
    for (int n = 0; n < lcg_frames; n++) begin
      old_data  = data;
      lcg_state = lcg_next(lcg_state);
      data      = lcg_state[20:16];
      if (data == old_data) data = data + 5'd1;
      set_data(data);
      receive_frame(bits);
      if (bits != uart_frame({3'b0, data})) begin
        compare_values("queued uart frame", {22'b0, bits},
                       {22'b0, uart_frame({3'b0, old_data})});
        check_frame(data);
      end
    end

    // Reset in the middle of a frame, back to square
    wait_start_edge();
    repeat (3 * bit_clocks) @(negedge clk_25mhz);
    apply_reset(1'b0, data);
    run_square();

    // And once more into UART
    lcg_state = lcg_next(lcg_state);
    data = lcg_state[20:16];
    apply_reset(1'b1, data);
    check_frame(data);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* logic/pio_board_top.sv */
`timescale 1ns/1ps
module pio_board_top (
  input  logic        clk_25mhz,
  input  logic [6:0]  btn,     // btn[0] low resets, btn[1] picks UART
  output logic [7:0]  led,
  output logic [27:0] gn
);

  logic                        reset;
  logic                        running;
  logic                        tx_empty;
  logic [3:0]                  action;
  logic [pio_pkg::data_w-1:0]  din;
  logic [pio_pkg::addr_w-1:0]  index;
  logic [pio_pkg::gpio_w-1:0]  gpio_out, gpio_dir;

  assign reset = ~btn[0];

  pio_loader u_loader (
    .clk_25mhz(clk_25mhz), .reset(reset), .mode_uart(btn[1]), .tx_byte(btn[6:2]),
    .tx_empty(tx_empty), .action(action), .din(din), .index(index), .running(running)
  );

  pio u_pio (
    .clk_25mhz(clk_25mhz), .reset(reset), .action(action), .din(din), .index(index),
    .tx_empty(tx_empty), .gpio_out(gpio_out), .gpio_dir(gpio_dir)
  );

  assign led = {reset, 5'b0, running, gpio_out[0]};
  assign gn  = {12'b0, gpio_dir[7:0], gpio_out[7:0]}; // Low pins and their directions

endmodule

/* logic/pio.sv */
`timescale 1ns/1ps
module pio (
  input  logic                        clk_25mhz,
  input  logic                        reset,
  input  logic [3:0]                  action,
  input  logic [pio_pkg::data_w-1:0]  din,
  input  logic [pio_pkg::addr_w-1:0]  index,
  output logic                        tx_empty,
  output logic [pio_pkg::gpio_w-1:0]  gpio_out,
  output logic [pio_pkg::gpio_w-1:0]  gpio_dir
);

  logic [pio_pkg::instr_w-1:0] imem [32];
  pio_pkg::pio_instr_t         instr;

  // Config registers
  logic [pio_pkg::addr_w-1:0] wrap_top, wrap_bottom;
  logic [pio_pkg::div_w-1:0]  div;
  logic [4:0]                 out_base, set_base, side_base;
  logic [5:0]                 out_count;
  logic [2:0]                 set_count;
  logic [1:0]                 sideset_count;
  logic                       enable;

  logic [pio_pkg::data_w-1:0] tx_data; // One-entry TX buffer
  logic                       tx_full;

  logic [2:0]                 opcode, dest, cond;
  logic [pio_pkg::addr_w-1:0] addr, pc;
  logic [4:0]                 imm, delay;
  logic [5:0]                 bit_count;
  logic                       side_en, pull_req, pin_wr, pin_sel, pin_kind, side_wr;
  logic [1:0]                 side_val, side_val_q;
  logic [pio_pkg::data_w-1:0] pin_data;

  always_ff @(posedge clk_25mhz) begin
    if (action == pio_pkg::act_instr) imem[index] <= din[pio_pkg::instr_w-1:0];
  end

  assign instr    = imem[pc];
  assign tx_empty = ~tx_full;

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      wrap_top      <= '1;
      wrap_bottom   <= '0;
      div           <= pio_pkg::div_w'(1);
      {out_base, out_count, set_base, set_count, side_base} <= '0;
      sideset_count <= '0;
      enable        <= 1'b0;
      tx_full       <= 1'b0;
    end else begin
      if (pull_req) tx_full <= 1'b0;
      case (action)
        pio_pkg::act_wrap: begin
          wrap_top    <= din[pio_pkg::wrap_top_lsb +: pio_pkg::addr_w];
          wrap_bottom <= din[pio_pkg::wrap_bottom_lsb +: pio_pkg::addr_w];
        end
        pio_pkg::act_pins: begin
          out_base  <= din[pio_pkg::out_base_lsb +: 5];
          out_count <= din[pio_pkg::out_count_lsb +: 6];
          set_base  <= din[pio_pkg::set_base_lsb +: 5];
          set_count <= din[pio_pkg::set_count_lsb +: 3];
          side_base <= din[pio_pkg::side_base_lsb +: 5];
        end
        pio_pkg::act_div:     div           <= din[pio_pkg::div_w-1:0];
        pio_pkg::act_sideset: sideset_count <= din[1:0];
        pio_pkg::act_enable:  enable        <= din[0];
        pio_pkg::act_tx:      tx_full       <= 1'b1;
        default:              enable        <= enable;
      endcase
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (action == pio_pkg::act_tx) tx_data <= din; // Payload only
  end

  pio_decode u_decode (
    .instr(instr), .sideset_count(sideset_count), .opcode(opcode), .dest(dest),
    .cond(cond), .addr(addr), .imm(imm), .bit_count(bit_count), .delay(delay),
    .side_en(side_en), .side_val(side_val)
  );

  pio_execute u_execute (
    .clk_25mhz(clk_25mhz), .reset(reset), .enable(enable), .div(div),
    .wrap_top(wrap_top), .wrap_bottom(wrap_bottom), .opcode(opcode), .dest(dest),
    .cond(cond), .addr(addr), .imm(imm), .bit_count(bit_count), .delay(delay),
    .side_en(side_en), .side_val(side_val), .tx_empty(tx_empty), .tx_data(tx_data),
    .pc(pc), .pull_req(pull_req), .pin_wr(pin_wr), .pin_sel(pin_sel),
    .pin_kind(pin_kind), .pin_data(pin_data), .side_wr(side_wr), .side_val_q(side_val_q)
  );

  pio_result u_result (
    .clk_25mhz(clk_25mhz), .reset(reset), .pin_wr(pin_wr), .pin_sel(pin_sel),
    .pin_kind(pin_kind), .pin_data(pin_data), .side_wr(side_wr), .side_val(side_val_q),
    .sideset_count(sideset_count), .out_base(out_base), .out_count(out_count),
    .set_base(set_base), .set_count(set_count), .side_base(side_base),
    .gpio_out(gpio_out), .gpio_dir(gpio_dir)
  );

endmodule

/* logic/pio_result.sv */
`timescale 1ns/1ps
module pio_result (
  input  logic                        clk_25mhz,
  input  logic                        reset,
  input  logic                        pin_wr,
  input  logic                        pin_sel,
  input  logic                        pin_kind,
  input  logic [pio_pkg::data_w-1:0]  pin_data,
  input  logic                        side_wr,
  input  logic [1:0]                  side_val,
  input  logic [1:0]                  sideset_count,
  input  logic [4:0]                  out_base,
  input  logic [5:0]                  out_count,
  input  logic [4:0]                  set_base,
  input  logic [2:0]                  set_count,
  input  logic [4:0]                  side_base,
  output logic [pio_pkg::gpio_w-1:0]  gpio_out,
  output logic [pio_pkg::gpio_w-1:0]  gpio_dir
);

  logic [4:0]                 base;
  logic [5:0]                 count;
  logic [pio_pkg::gpio_w-1:0] wmask, wdata, smask, sdata, out_next;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] b);
    logic [63:0] t;
    t = {v, v} << b;
    return t[63:32];
  endfunction

  // Group of the pending write
  assign base  = (pin_kind == pio_pkg::kind_out) ? out_base : set_base;
  assign count = (pin_kind == pio_pkg::kind_out) ? out_count : {3'b000, set_count};
  assign wmask = rotl(~({pio_pkg::gpio_w{1'b1}} << count), base);
  assign wdata = rotl(pin_data, base);
  assign smask = rotl(~({pio_pkg::gpio_w{1'b1}} << sideset_count), side_base);
  assign sdata = rotl({30'b0, side_val}, side_base);

  always_comb begin
    out_next = gpio_out;
    if (pin_wr && pin_sel == pio_pkg::pin_sel_pins)
      out_next = (out_next & ~wmask) | (wdata & wmask);
    if (side_wr)
      out_next = (out_next & ~smask) | (sdata & smask); // Side-set wins
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      gpio_out <= '0;
      gpio_dir <= '0;
    end else begin
      gpio_out <= out_next;
      if (pin_wr && pin_sel == pio_pkg::pin_sel_dirs)
        gpio_dir <= (gpio_dir & ~wmask) | (wdata & wmask);
    end
  end

endmodule

/* logic/pio_execute.sv */
`timescale 1ns/1ps
module pio_execute (
  input  logic                         clk_25mhz,
  input  logic                         reset,
  input  logic                         enable,
  input  logic [pio_pkg::div_w-1:0]    div,
  input  logic [pio_pkg::addr_w-1:0]   wrap_top,
  input  logic [pio_pkg::addr_w-1:0]   wrap_bottom,
  input  logic [2:0]                   opcode,
  input  logic [2:0]                   dest,
  input  logic [2:0]                   cond,
  input  logic [pio_pkg::addr_w-1:0]   addr,
  input  logic [4:0]                   imm,
  input  logic [5:0]                   bit_count,
  input  logic [4:0]                   delay,
  input  logic                         side_en,
  input  logic [1:0]                   side_val,
  input  logic                         tx_empty,
  input  logic [pio_pkg::data_w-1:0]   tx_data,
  output logic [pio_pkg::addr_w-1:0]   pc,
  output logic                         pull_req,
  output logic                         pin_wr,
  output logic                         pin_sel,
  output logic                         pin_kind,
  output logic [pio_pkg::data_w-1:0]   pin_data,
  output logic                         side_wr,
  output logic [1:0]                   side_val_q
);

  logic [pio_pkg::div_w-1:0]  div_cnt;
  logic [pio_pkg::div_w-1:0]  div_eff;
  logic                       tick;
  logic [4:0]                 delay_cnt;
  logic [pio_pkg::data_w-1:0] x, y, osr;
  logic [pio_pkg::data_w-1:0] out_bits;
  logic [pio_pkg::addr_w-1:0] pc_next;
  logic                       jmp_take;

  assign div_eff  = (div == '0) ? pio_pkg::div_w'(1) : div; // 0 acts as 1
  assign tick     = enable && (div_cnt == div_eff - 1'b1);
  assign pc_next  = (pc == wrap_top) ? wrap_bottom : pc + 1'b1;
  assign out_bits = osr & ~({pio_pkg::data_w{1'b1}} << bit_count); // Low bits of OSR

  // Tested on the old x and y
  always_comb begin
    case (cond)
      pio_pkg::cond_x_zero: jmp_take = (x == '0);
      pio_pkg::cond_x_dec:  jmp_take = (x != '0);
      pio_pkg::cond_y_zero: jmp_take = (y == '0);
      pio_pkg::cond_y_dec:  jmp_take = (y != '0);
      default:              jmp_take = 1'b1;
    endcase
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset || !enable) div_cnt <= '0;
    else if (tick)        div_cnt <= '0;
    else                  div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk_25mhz) begin
    pin_wr   <= 1'b0; // Strobes
    pull_req <= 1'b0;
    side_wr  <= 1'b0;
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else if (tick) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 5'd1;
      end else begin
        side_wr    <= side_en;
        side_val_q <= side_val;
        delay_cnt  <= delay;
        pc         <= pc_next;
        case (opcode)
          pio_pkg::op_jmp: begin
            if (cond == pio_pkg::cond_x_dec) x <= x - 1'b1;
            if (cond == pio_pkg::cond_y_dec) y <= y - 1'b1;
            if (jmp_take) pc <= addr;
          end
          pio_pkg::op_set: begin
            pin_sel  <= (dest == pio_pkg::dst_pindirs) ? pio_pkg::pin_sel_dirs
                                                       : pio_pkg::pin_sel_pins;
            pin_kind <= pio_pkg::kind_set;
            pin_data <= {27'b0, imm};
            if (dest == pio_pkg::dst_pins || dest == pio_pkg::dst_pindirs) pin_wr <= 1'b1;
            if (dest == pio_pkg::dst_x) x <= {27'b0, imm};
            if (dest == pio_pkg::dst_y) y <= {27'b0, imm};
          end
          pio_pkg::op_out: begin
            osr      <= osr >> bit_count; // Right shift, 32 empties it
            pin_sel  <= pio_pkg::pin_sel_pins;
            pin_kind <= pio_pkg::kind_out;
            pin_data <= out_bits;
            if (dest == pio_pkg::dst_pins) pin_wr <= 1'b1;
            if (dest == pio_pkg::dst_x) x <= out_bits;
            if (dest == pio_pkg::dst_y) y <= out_bits;
          end
          pio_pkg::op_pull: begin
            if (tx_empty) begin
              pc        <= pc; // Stall, retry next tick
              delay_cnt <= 5'd0;
            end else begin
              osr      <= tx_data;
              pull_req <= 1'b1;
            end
          end
          default: pc <= pc_next;
        endcase
      end
    end
  end

endmodule

/* logic/pio_decode.sv */
`timescale 1ns/1ps
module pio_decode (
  input  pio_pkg::pio_instr_t instr,
  input  logic [1:0]          sideset_count,
  output logic [2:0]          opcode,
  output logic [2:0]          dest,
  output logic [2:0]          cond,
  output logic [4:0]          addr,
  output logic [4:0]          imm,
  output logic [5:0]          bit_count,
  output logic [4:0]          delay,
  output logic                side_en,
  output logic [1:0]          side_val
);

  logic [4:0] ds; // Shared delay and side-set field

  assign opcode = instr.jmp_f.opcode;
  assign ds     = instr.jmp_f.delay_side;

  // Operand fields through the opcode's own view
  always_comb begin
    dest      = '0;
    cond      = pio_pkg::cond_always;
    addr      = '0;
    imm       = '0;
    bit_count = 6'd32;
    case (opcode)
      pio_pkg::op_jmp: begin
        cond = instr.jmp_f.cond;
        addr = instr.jmp_f.addr;
      end
      pio_pkg::op_set: begin
        dest = instr.set_f.dest;
        imm  = instr.set_f.data;
      end
      pio_pkg::op_out: begin
        dest = instr.out_f.dest;
        if (instr.out_f.bit_count != 5'd0)
          bit_count = {1'b0, instr.out_f.bit_count}; // 0 stays 32
      end
      default: dest = '0;
    endcase
  end

  // Side-set takes the top bits, delay the rest
  always_comb begin
    case (sideset_count)
      2'd0: begin
        delay    = ds;
        side_en  = 1'b0;
        side_val = 2'b00;
      end
      2'd1: begin
        delay    = {1'b0, ds[3:0]};
        side_en  = 1'b1;
        side_val = {1'b0, ds[4]};
      end
      default: begin
        delay    = {2'b00, ds[2:0]};
        side_en  = 1'b1;
        side_val = ds[4:3];
      end
    endcase
  end

endmodule

/* logic/pio_loader.sv */
`timescale 1ns/1ps
module pio_loader (
  input  logic                            clk_25mhz,
  input  logic                            reset,
  input  logic                            mode_uart, // Sampled while in reset
  input  logic [4:0]                      tx_byte,
  input  logic                            tx_empty,
  output logic [3:0]                      action,
  output logic [pio_pkg::data_w-1:0]      din,
  output logic [pio_pkg::addr_w-1:0]      index,
  output logic                            running
);

  logic [1:0] state;
  logic [4:0] cnt;     // Word counter, shared by both phases
  logic       mode_q;

  // Program ROM, unused slots are jmp 0
  function automatic logic [15:0] prog_word(input logic uart, input logic [4:0] a);
    logic [15:0] w;
    w = 16'h0000;
    if (uart) begin
      case (a)
        5'd0: w = 16'b111_00000_100_00001; // set pindirs 1 side 0
        5'd1: w = 16'b111_00000_000_00001; // set pins 1 side 0, line idle
        5'd2: w = 16'b100_00000_01000000;  // pull block side 0
        5'd3: w = 16'b111_10000_001_00111; // set x 7 side 1
        5'd4: w = 16'b111_10111_000_00000; // Start bit [7]
        5'd5: w = 16'b011_10000_000_00001; // out pins 1 side 1
        5'd6: w = 16'b000_10110_010_00101; // jmp x-- 5 side 1 [6]
        5'd7: w = 16'b111_00111_000_00001; // Stop bit [7]
        default: w = 16'h0000;
      endcase
    end else begin
      case (a)
        5'd0: w = 16'b111_00000_100_00001; // set pindirs 1
        5'd1: w = 16'b111_00001_000_00001; // set pins 1 [1]
        5'd2: w = 16'b111_00000_000_00000; // set pins 0
        5'd3: w = 16'b000_00000_000_00001; // jmp 1
        default: w = 16'h0000;
      endcase
    end
    return w;
  endfunction

  // Config list as {action, data}
  function automatic logic [35:0] conf_word(input logic uart, input logic [2:0] i);
    logic [35:0] w;
    case (i)
      3'd0: w = {pio_pkg::act_wrap, uart ? 32'h0000_0207 : 32'h0000_0003};
      3'd1: w = {pio_pkg::act_div, 32'd2}; // Tick every 2 clocks
      3'd2: w = {pio_pkg::act_pins, uart ? 32'h0009_0020 : 32'h0001_0020};
      3'd3: w = {pio_pkg::act_sideset, uart ? 32'd1 : 32'd0};
      default: w = {pio_pkg::act_enable, 32'd1}; // Must be last
    endcase
    return w;
  endfunction

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      state  <= pio_pkg::ld_prog;
      cnt    <= '0;
      action <= pio_pkg::act_none;
      mode_q <= mode_uart;
    end else begin
      action <= pio_pkg::act_none;
      case (state)
        pio_pkg::ld_prog: begin
          action <= pio_pkg::act_instr;
          din    <= {16'b0, prog_word(mode_q, cnt)};
          index  <= cnt;
          cnt    <= cnt + 5'd1; // Wraps to 0 after the last word
          if (cnt == 5'd31) state <= pio_pkg::ld_conf;
        end
        pio_pkg::ld_conf: begin
          {action, din} <= conf_word(mode_q, cnt[2:0]);
          cnt <= cnt + 5'd1;
          if (cnt == 5'(pio_pkg::conf_len - 1)) state <= pio_pkg::ld_run;
        end
        pio_pkg::ld_run: begin
          // Refill, one clock gap against a double push
          if (tx_empty && action != pio_pkg::act_tx) begin
            action <= pio_pkg::act_tx;
            din    <= {27'b0, tx_byte};
          end
        end
        default: state <= pio_pkg::ld_prog;
      endcase
    end
  end

  assign running = (state == pio_pkg::ld_run);

endmodule

/* logic/pio_pkg.sv */
package pio_pkg;

  // Widths
  localparam int instr_w = 16;
  localparam int addr_w  = 5;
  localparam int data_w  = 32;
  localparam int gpio_w  = 32;
  localparam int div_w   = 16;

  // Loader to PIO action codes
  localparam logic [3:0] act_none    = 4'd0;
  localparam logic [3:0] act_instr   = 4'd1; // One instruction word
  localparam logic [3:0] act_wrap    = 4'd2;
  localparam logic [3:0] act_tx      = 4'd4; // TX buffer push
  localparam logic [3:0] act_pins    = 4'd5;
  localparam logic [3:0] act_enable  = 4'd6;
  localparam logic [3:0] act_div     = 4'd7;
  localparam logic [3:0] act_sideset = 4'd8;

  // Opcodes, top three bits of the word
  localparam logic [2:0] op_jmp  = 3'd0;
  localparam logic [2:0] op_out  = 3'd3;
  localparam logic [2:0] op_pull = 3'd4;
  localparam logic [2:0] op_set  = 3'd7;

  // Destinations for set and out
  localparam logic [2:0] dst_pins    = 3'd0;
  localparam logic [2:0] dst_x       = 3'd1;
  localparam logic [2:0] dst_y       = 3'd2;
  localparam logic [2:0] dst_null    = 3'd3; // out only
  localparam logic [2:0] dst_pindirs = 3'd4; // set only

  // Jump conditions
  localparam logic [2:0] cond_always = 3'd0;
  localparam logic [2:0] cond_x_zero = 3'd1;
  localparam logic [2:0] cond_x_dec  = 3'd2;
  localparam logic [2:0] cond_y_zero = 3'd3;
  localparam logic [2:0] cond_y_dec  = 3'd4;

  // Pin write select and kind
  localparam logic pin_sel_pins = 1'b0;
  localparam logic pin_sel_dirs = 1'b1;
  localparam logic kind_set     = 1'b0;
  localparam logic kind_out     = 1'b1;

  // Loader sequencer states
  localparam logic [1:0] ld_prog = 2'd0;
  localparam logic [1:0] ld_conf = 2'd1;
  localparam logic [1:0] ld_run  = 2'd2;
  localparam int conf_len = 5;

  // Config word field positions
  localparam int wrap_top_lsb    = 0;
  localparam int wrap_bottom_lsb = 8;
  localparam int out_base_lsb    = 0;
  localparam int out_count_lsb   = 5;
  localparam int set_base_lsb    = 11;
  localparam int set_count_lsb   = 16;
  localparam int side_base_lsb   = 19;

  typedef struct packed {
    logic [2:0] opcode;
    logic [4:0] delay_side;
    logic [2:0] cond;
    logic [4:0] addr;
  } jmp_f_t;

  typedef struct packed {
    logic [2:0] opcode;
    logic [4:0] delay_side;
    logic [2:0] dest;
    logic [4:0] data;
  } set_f_t;

  typedef struct packed {
    logic [2:0] opcode;
    logic [4:0] delay_side;
    logic [2:0] dest;
    logic [4:0] bit_count; // 0 stands for 32
  } out_f_t;

  typedef struct packed {
    logic [2:0] opcode;
    logic [4:0] delay_side;
    logic       if_empty;
    logic       block;
    logic [5:0] unused;
  } pull_f_t;

  typedef union packed {
    jmp_f_t  jmp_f;
    set_f_t  set_f;
    out_f_t  out_f;
    pull_f_t pull_f;
  } pio_instr_t;

endpackage
